/* design/fetch_pkg.sv */
// Fetch stage shared definitions
package fetch_pkg;

   // --------------------
   // sizes
   // --------------------
   localparam int PC_SZ        = 32;                  // program counter width
   localparam int INSTR_SZ     = 32;                  // every word is a 32 bit instruction
   localparam int IPCL         = 8;                   // instructions per cache line
   localparam int CL_LEN       = 32;                  // cache line length in bytes
   localparam int CL_SZ        = 5;                   // byte offset bits within a line
   localparam int LINE_BITS    = CL_LEN * 8;          // 256 bit line
   localparam int CNT_SZ       = $clog2(IPCL + 1);    // holds 0..IPCL

   localparam logic [PC_SZ-1:0] RESET_VECTOR = '0;

   // --------------------
   // payload types
   // --------------------
   typedef struct packed {
      logic [INSTR_SZ-1:0]   instruction;
      logic [PC_SZ-1:0]      pc;
      logic [PC_SZ-1:0]      predicted_addr;     // where fetch expects to go next
   } fetch_entry_t;

   // one predecoded line, slots 0..count-1 valid
   typedef struct packed {
      logic [CNT_SZ-1:0]        count;
      fetch_entry_t [IPCL-1:0]  slot;
   } line_write_t;

   // return address stack hint from the link registers
   typedef enum logic [1:0] {
      ras_none,
      ras_push,
      ras_pop,
      ras_pop_push
   } ras_op_t;

   typedef struct packed {
      logic                   ack;              // line is on the bus this cycle
      logic [LINE_BITS-1:0]   line;
   } icache_resp_t;

endpackage

/* design/line_requester.sv */
// Cache line request control
`timescale 1ns/1ps

module line_requester
(
   input  logic                          clk_in,
   input  logic                          reset_in,
   input  logic                          pc_reload,
   input  logic [fetch_pkg::PC_SZ-1:0]   pc_reload_addr,
   input  logic                          queue_full,
   input  logic                          ic_ack,
   input  logic [fetch_pkg::PC_SZ-1:0]   next_line_pc,     // last prediction of this line
   output logic                          ic_req,
   output logic [fetch_pkg::PC_SZ-1:0]   pc,
   output logic                          line_valid
);
   typedef enum logic [1:0] {st_idle, st_ack, st_reload_ack} req_state_t;

   req_state_t                    state, next_state;
   logic [fetch_pkg::PC_SZ-1:0]   next_pc;
   logic [fetch_pkg::PC_SZ-1:0]   lpa;                 // last predicted address
   logic [fetch_pkg::PC_SZ-1:0]   reload_addr;
   logic                          reload_flag;         // reload seen, not yet fetched
   logic                          next_req;
   logic                          xfer;

   assign xfer = ic_req & ic_ack;                      // line moves this edge

   // stale lines are dropped until the reload line itself arrives
   assign line_valid = xfer & !pc_reload & (!reload_flag | (state == st_reload_ack));

   always_comb
   begin
      next_state = state;
      next_pc    = pc;
      next_req   = ic_req;
      case (state)
         st_idle:
         begin
            next_pc = reload_flag ? reload_addr : lpa;
            if (!queue_full && !pc_reload)
            begin
               next_req   = 1'b1;
               next_state = reload_flag ? st_reload_ack : st_ack;
            end
         end
         st_ack, st_reload_ack:
         begin
            if (xfer)
            begin
               next_req   = 1'b0;
               next_state = st_idle;
            end
            else if (pc_reload)
               next_state = st_ack;                    // request in flight is now old path
         end
         default: next_state = st_idle;
      endcase
   end

   always_ff @(posedge clk_in)
   begin
      if (reset_in)
      begin
         state       <= st_idle;
         ic_req      <= 1'b0;
         pc          <= fetch_pkg::RESET_VECTOR;
         lpa         <= fetch_pkg::RESET_VECTOR;
         reload_flag <= 1'b0;
      end
      else
      begin
         state  <= next_state;
         ic_req <= next_req;
         pc     <= next_pc;
         if (xfer)
            lpa <= next_line_pc;                       // continue from the line's last guess
         if (pc_reload)
            reload_flag <= 1'b1;                       // new reload wins over a clear
         else if (xfer && (state == st_reload_ack))
            reload_flag <= 1'b0;
      end
      if (pc_reload)
         reload_addr <= pc_reload_addr;
   end

endmodule

/* design/line_predecoder.sv */
// Line split and branch predecode
`timescale 1ns/1ps

module line_predecoder
(
   input  logic [fetch_pkg::PC_SZ-1:0]      pc,
   input  logic [fetch_pkg::LINE_BITS-1:0]  line,
   input  logic                             line_valid,
   input  logic [fetch_pkg::CNT_SZ-1:0]     queue_space,
   input  logic [fetch_pkg::PC_SZ-1:0]      ras_top,
   output fetch_pkg::line_write_t           line_wr,
   output logic [fetch_pkg::PC_SZ-1:0]      next_line_pc,
   output fetch_pkg::ras_op_t               ras_op,
   output logic [fetch_pkg::PC_SZ-1:0]      ras_push_addr
);
   localparam int IS = fetch_pkg::INSTR_SZ;

   logic [IS-1:0]                   instr;
   logic [fetch_pkg::PC_SZ-1:0]     addr;           // pc of the word being looked at
   logic [fetch_pkg::PC_SZ-1:0]     pred;
   logic [31:0]                     i_imm, b_imm, j_imm;
   logic [4:0]                      rd, rs1;
   logic                            link_rd, link_rs1;
   logic                            taken;
   logic                            done;
   logic [fetch_pkg::CNT_SZ-1:0]    cnt;            // entries written so far
   logic [fetch_pkg::CL_SZ-3:0]     first;          // word index of pc in the line

   assign first = pc[fetch_pkg::CL_SZ-1:2];

   always_comb
   begin
      line_wr       = '0;
      next_line_pc  = pc;                           // nothing written, refetch same pc
      ras_op        = fetch_pkg::ras_none;
      ras_push_addr = '0;
      addr          = pc;
      cnt           = '0;
      done          = !line_valid;
      instr         = '0;
      pred          = '0;
      i_imm         = '0;
      b_imm         = '0;
      j_imm         = '0;
      rd            = '0;
      rs1           = '0;
      link_rd       = 1'b0;
      link_rs1      = 1'b0;
      taken         = 1'b0;

      for (int w = 0; w < fetch_pkg::IPCL; w++)
      begin
         if (!done && (w >= first) && (cnt < queue_space))
         begin
            instr    = line[w*IS +: IS];
            i_imm    = {{21{instr[31]}}, instr[30:20]};
            b_imm    = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            j_imm    = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            rd       = instr[11:7];
            rs1      = instr[19:15];
            link_rd  = (rd == 5'd1) | (rd == 5'd5);     // x1 / x5 are link registers
            link_rs1 = (rs1 == 5'd1) | (rs1 == 5'd5);
            pred     = addr + 32'd4;                    // sequential by default
            taken    = 1'b0;

            case (instr[6:0])
               7'b1101111:                              // JAL, always taken
               begin
                  pred  = addr + j_imm;
                  taken = 1'b1;
                  if (link_rd)
                  begin
                     ras_op        = fetch_pkg::ras_push;   // call
                     ras_push_addr = addr + 32'd4;
                  end
               end
               7'b1100111:                              // JALR
               begin
                  if (instr[14:12] == 3'b000)
                  begin
                     taken = 1'b1;
                     case ({link_rd, link_rs1})
                        2'b01:   ras_op = fetch_pkg::ras_pop;
                        2'b10:   ras_op = fetch_pkg::ras_push;
                        2'b11:   ras_op = (rd == rs1) ? fetch_pkg::ras_push
                                                      : fetch_pkg::ras_pop_push;
                        default: ras_op = fetch_pkg::ras_none;
                     endcase
                     if (ras_op != fetch_pkg::ras_none)
                        ras_push_addr = addr + 32'd4;
                     // returns come off the stack, anything else guesses rs1 = x0
                     if ((ras_op == fetch_pkg::ras_pop) || (ras_op == fetch_pkg::ras_pop_push))
                        pred = ras_top;
                     else
                        pred = i_imm;
                  end
               end
               7'b1100011:                              // Bxx, backward taken
               begin
                  taken = b_imm[31];
                  if (b_imm[31])
                     pred = addr + b_imm;
               end
               default: ;
            endcase

            line_wr.slot[cnt].instruction    = instr;
            line_wr.slot[cnt].pc             = addr;
            line_wr.slot[cnt].predicted_addr = pred;
            cnt          = cnt + 1'b1;
            next_line_pc = pred;
            addr         = pred;                        // pc + 4 unless taken
            done         = taken;                       // rest of line is off path
         end
      end
      line_wr.count = cnt;
   end

endmodule

/* design/return_stack.sv */
// Return address stack
`timescale 1ns/1ps

module return_stack
#(
   parameter int RAS_DEPTH = 8                          // power of two, pointer wraps
)
(
   input  logic                          clk_in,
   input  logic                          reset_in,
   input  logic                          line_valid,
   input  fetch_pkg::ras_op_t            op,
   input  logic [fetch_pkg::PC_SZ-1:0]   push_addr,
   output logic [fetch_pkg::PC_SZ-1:0]   top
);
   localparam int RP_SZ = $clog2(RAS_DEPTH);

   logic [RAS_DEPTH-1:0][fetch_pkg::PC_SZ-1:0]  ras;
   logic [RP_SZ-1:0]                            ras_ptr;    // next free slot
   logic [RP_SZ-1:0]                            top_ptr;

   assign top_ptr = ras_ptr - 1'b1;                    // most recent push
   assign top     = ras[top_ptr];

   always_ff @(posedge clk_in)
   begin
      if (reset_in)
      begin
         ras_ptr <= '0;
         ras     <= '0;
      end
      else if (line_valid)
      begin
         case (op)
            fetch_pkg::ras_push:
            begin
               ras[ras_ptr] <= push_addr;               // overwrites oldest on overflow
               ras_ptr      <= ras_ptr + 1'b1;
            end
            fetch_pkg::ras_pop:      ras_ptr <= top_ptr;
            fetch_pkg::ras_pop_push: ras[top_ptr] <= push_addr;    // replace top in place
            default: ;
         endcase
      end
   end

endmodule

/* design/instr_queue.sv */
// Instruction queue to decode
`timescale 1ns/1ps

module instr_queue
#(
   parameter int QUEUE_DEPTH = 16                      // at least one full line
)
(
   input  logic                             clk_in,
   input  logic                             reset_in,
   input  logic                             flush,
   input  fetch_pkg::line_write_t           line_wr,
   input  logic                             f2d_ready,
   output logic                             f2d_valid,
   output fetch_pkg::fetch_entry_t          f2d_data,
   output logic [fetch_pkg::CNT_SZ-1:0]     space,
   output logic                             full
);
   localparam int PTR_SZ = $clog2(QUEUE_DEPTH);
   localparam int QC_SZ  = $clog2(QUEUE_DEPTH + 1);
   localparam int CS     = fetch_pkg::CNT_SZ;

   fetch_pkg::fetch_entry_t   que [QUEUE_DEPTH];
   logic [PTR_SZ-1:0]         qip;                     // input pointer
   logic [PTR_SZ-1:0]         qop;                     // output pointer
   logic [QC_SZ-1:0]          qcnt;
   logic [QC_SZ-1:0]          free;
   logic                      xfer_out;

   // pointer add with wrap, depth need not be a power of two
   function automatic logic [PTR_SZ-1:0] wrap_add(input logic [PTR_SZ-1:0] p,
                                                  input int unsigned k);
      int unsigned s;
      s = p + k;
      if (s >= QUEUE_DEPTH)
         s = s - QUEUE_DEPTH;
      return s[PTR_SZ-1:0];
   endfunction

   assign f2d_valid = (qcnt != '0);
   assign f2d_data  = que[qop];                        // head held while stalled
   assign xfer_out  = f2d_valid & f2d_ready;
   assign full      = (qcnt == QC_SZ'(QUEUE_DEPTH));
   assign free      = QC_SZ'(QUEUE_DEPTH) - qcnt;
   assign space     = (free > QC_SZ'(fetch_pkg::IPCL)) ? CS'(fetch_pkg::IPCL) : CS'(free);

   // --------------------
   // storage, up to IPCL writes per edge
   // --------------------
   always_ff @(posedge clk_in)
   begin
      for (int k = 0; k < fetch_pkg::IPCL; k++)
         if (k < line_wr.count)
            que[wrap_add(qip, k)] <= line_wr.slot[k];
   end

   // --------------------
   // pointers and count
   // --------------------
   always_ff @(posedge clk_in)
   begin
      if (reset_in || flush)
      begin
         qip  <= '0;
         qop  <= '0;
         qcnt <= '0;
      end
      else
      begin
         qip  <= wrap_add(qip, line_wr.count);
         qcnt <= qcnt + QC_SZ'(line_wr.count) - QC_SZ'(xfer_out);  // in and out together
         if (xfer_out)
            qop <= wrap_add(qop, 1);
      end
   end

endmodule

/* design/fetch_unit.sv */
// Instruction fetch stage top
`timescale 1ns/1ps

module fetch_unit
#(
   parameter int QUEUE_DEPTH = 16,
   parameter int RAS_DEPTH   = 8
)
(
   input  logic                          clk_in,
   input  logic                          reset_in,
   input  logic                          pc_reload,
   input  logic [fetch_pkg::PC_SZ-1:0]   pc_reload_addr,
   output logic                          ic_req,
   output logic [fetch_pkg::PC_SZ-1:0]   ic_addr,
   input  fetch_pkg::icache_resp_t       ic_resp,
   output logic                          f2d_valid,
   output fetch_pkg::fetch_entry_t       f2d_data,
   input  logic                          f2d_ready
);
   logic                          line_valid;
   logic                          queue_full;
   logic [fetch_pkg::CNT_SZ-1:0]  queue_space;
   logic [fetch_pkg::PC_SZ-1:0]   next_line_pc;
   logic [fetch_pkg::PC_SZ-1:0]   ras_top, ras_push_addr;
   fetch_pkg::ras_op_t            ras_op;
   fetch_pkg::line_write_t        line_wr;

   line_requester u_req (
      .clk_in         (clk_in),
      .reset_in       (reset_in),
      .pc_reload      (pc_reload),
      .pc_reload_addr (pc_reload_addr),
      .queue_full     (queue_full),
      .ic_ack         (ic_resp.ack),
      .next_line_pc   (next_line_pc),
      .ic_req         (ic_req),
      .pc             (ic_addr),          // cache address is the fetch pc
      .line_valid     (line_valid)
   );

   line_predecoder u_pre (
      .pc             (ic_addr),
      .line           (ic_resp.line),
      .line_valid     (line_valid),
      .queue_space    (queue_space),
      .ras_top        (ras_top),
      .line_wr        (line_wr),
      .next_line_pc   (next_line_pc),
      .ras_op         (ras_op),
      .ras_push_addr  (ras_push_addr)
   );

   return_stack #(.RAS_DEPTH(RAS_DEPTH)) u_ras (
      .clk_in, .reset_in, .line_valid,
      .op (ras_op), .push_addr (ras_push_addr), .top (ras_top)
   );

   instr_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_que (
      .clk_in, .reset_in, .flush (pc_reload), .line_wr, .f2d_ready,
      .f2d_valid, .f2d_data, .space (queue_space), .full (queue_full)
   );

endmodule

/* dv/icache_model.sv */
// Instruction cache model
`timescale 1ns/1ps

module icache_model
(
   input  logic                          clk_in,
   input  logic                          reset_in,
   input  logic                          ic_req,
   input  logic [fetch_pkg::PC_SZ-1:0]   ic_addr,
   output fetch_pkg::icache_resp_t       ic_resp
);
   logic [31:0]   prog [64];                    // 256 byte program, upper address bits ignored
   logic          busy;                         // request seen, delay running
   int unsigned   delay;

   initial
   begin
      ic_resp = '0;
      busy    = 1'b0;
      delay   = 0;
      for (int i = 0; i < 64; i++)
         prog[i] = {12'(i), 5'd2, 3'b000, 5'd2, 7'b0010011};   // addi x2, x2, index
      prog[0]  = 32'h00100193;                  // addi x3, x0, 1
      prog[1]  = 32'h00200213;                  // addi x4, x0, 2
      prog[2]  = 32'h00418863;                  // beq x3, x4, +16   forward
      prog[5]  = 32'h00118193;                  // loop: addi x3, x3, 1
      prog[7]  = 32'hfe419ce3;                  // bne x3, x4, -8    backward
      prog[8]  = 32'h040000ef;                  // jal x1, +0x40     outer call
      prog[10] = 32'h0180006f;                  // jal x0, +0x18     plain jump
      prog[17] = 32'h0a030067;                  // jalr x0, 0xa0(x6) no link
      prog[25] = 32'h01c002ef;                  // jal x5, +0x1c     nested call
      prog[26] = 32'h00008067;                  // jalr x0, 0(x1)    outer return
      prog[33] = 32'h00028067;                  // jalr x0, 0(x5)    nested return
   end

   // acknowledge after 0 to 3 cycles, line follows the address
   always @(negedge clk_in)
   begin
      if (reset_in || !ic_req)
      begin
         busy        = 1'b0;
         ic_resp.ack = 1'b0;
      end
      else
      begin
         if (!busy)
         begin
            busy  = 1'b1;
            delay = $urandom % 4;               // new request
         end
         ic_resp.ack = (delay == 0);
         if (delay != 0)
            delay = delay - 1;
      end
      for (int w = 0; w < fetch_pkg::IPCL; w++)
         ic_resp.line[w*32 +: 32] = prog[{ic_addr[7:5], 3'(w)}];
   end

endmodule

/* dv/fetch_unit_tb.sv */
// Fetch stage testbench
`timescale 1ns/1ps

module fetch_unit_tb;
   localparam int  RAS_DEPTH  = 8;
   localparam int  MAX_CYCLES = 3000;            // two program passes with stalls need well under 1000
   localparam logic [31:0] PASS2_BASE = 32'h400;    // second pass runs the program again here

   logic                          clk_in = 1'b0;
   logic                          reset_in;
   logic                          pc_reload;
   logic [fetch_pkg::PC_SZ-1:0]   pc_reload_addr;
   logic                          f2d_ready;
   logic                          ic_req;
   logic [fetch_pkg::PC_SZ-1:0]   ic_addr;
   logic                          f2d_valid;
   fetch_pkg::icache_resp_t       ic_resp;
   fetch_pkg::fetch_entry_t       f2d_data;

   logic [31:0]               exp_pc;            // where the next accepted entry must be
   logic [31:0]               ras_q [$];         // reference return stack
   logic [31:0]               exit_addr;
   fetch_pkg::fetch_entry_t   held;
   logic                      hold_chk;
   logic                      req_open;          // request seen without its transfer
   logic                      from_reset;
   logic [31:0]               req_addr;
   bit                        loop_exit, pass_end, run_done;
   int                        errors, n_accept, n_return, n_reload, n_stall;
   int                        loop_hits, passes, cycles;

   fetch_unit #(.QUEUE_DEPTH(16), .RAS_DEPTH(RAS_DEPTH)) DUT (
      .clk_in, .reset_in, .pc_reload, .pc_reload_addr, .ic_req, .ic_addr,
      .ic_resp, .f2d_valid, .f2d_data, .f2d_ready
   );

   icache_model icache (.clk_in, .reset_in, .ic_req, .ic_addr, .ic_resp);

   always #50 clk_in = ~clk_in;

   // --------------------
   // reporting
   // --------------------
   task automatic report_value(input string name, input logic [95:0] want, input logic [95:0] got);
      errors++;
      $display("error %s: expected %0h, got %0h at %0t", name, want, got, $time);
   endtask

   task automatic report_failure(input string what);
      errors++;
      $display("failure: %s", what);
   endtask

   task automatic end_run(input bit timed_out);
      $display("entries %0d, returns %0d, reloads %0d, stall checks %0d, errors %0d, timeout %0d",
               n_accept, n_return, n_reload, n_stall, errors, timed_out);
      if ((errors == 0) && !timed_out)
         $display("NO ERRORS");
      else
         $display("ERRORS FOUND");
      $finish;
   endtask

   // --------------------
   // reference predictor
   // --------------------
   task automatic predict_next(input logic [31:0] instr, input logic [31:0] pc,
                               output logic [31:0] pred);
      logic [31:0] imm_i, imm_b, imm_j;
      logic        rd_link, rs1_link, do_pop, do_push;
      imm_i    = 32'($signed(instr[31:20]));
      imm_b    = 32'($signed({instr[31], instr[7], instr[30:25], instr[11:8], 1'b0}));
      imm_j    = 32'($signed({instr[31], instr[19:12], instr[20], instr[30:21], 1'b0}));
      rd_link  = (instr[11:7] == 5'd1) || (instr[11:7] == 5'd5);
      rs1_link = (instr[19:15] == 5'd1) || (instr[19:15] == 5'd5);
      do_pop   = 1'b0;
      do_push  = 1'b0;
      pred     = pc + 32'd4;
      case (instr[6:0])
         7'b1101111:                              // jal
         begin
            pred    = pc + imm_j;
            do_push = rd_link;
         end
         7'b1100111:                              // jalr, rd == rs1 link means push only
         begin
            do_push = rd_link;
            do_pop  = rs1_link && !(rd_link && (instr[11:7] == instr[19:15]));
            if (do_pop)
               pred = (ras_q.size() > 0) ? ras_q[$] : 32'd0;
            else
               pred = imm_i;
         end
         7'b1100011:                              // backward taken, forward not
         begin
            if (imm_b[31])
               pred = pc + imm_b;
         end
         default: ;
      endcase
      if (do_pop)
      begin
         n_return++;
         if (ras_q.size() > 0)
            void'(ras_q.pop_back());
      end
      if (do_push)
      begin
         ras_q.push_back(pc + 32'd4);
         if (ras_q.size() > RAS_DEPTH)
            void'(ras_q.pop_front());             // oldest lost on overflow
      end
   endtask

   task automatic check_entry(input fetch_pkg::fetch_entry_t e);
      logic [31:0] want_instr, want_pred;
      want_instr = icache.prog[e.pc[7:2]];
      predict_next(want_instr, e.pc, want_pred);
      assert (e.pc == exp_pc) else report_value("f2d_data.pc", exp_pc, e.pc);
      assert (e.instruction == want_instr)
         else report_value("f2d_data.instruction", want_instr, e.instruction);
      assert (e.predicted_addr == want_pred)
         else report_value("f2d_data.predicted_addr", want_pred, e.predicted_addr);
      exp_pc = e.predicted_addr;                   // path continues where the entry points
      n_accept++;
      if (e.pc[7:0] == 8'h1c)
      begin
         loop_hits++;
         if (loop_hits == 4)
         begin
            loop_exit = 1'b1;                      // resolve the loop branch as not taken
            exit_addr = e.pc + 32'd4;
         end
      end
      if (e.pc[7:0] == 8'hfc)
      begin
         pass_end  = 1'b1;                         // end of the sequential run
         loop_hits = 0;
         passes++;
      end
   endtask

   // checks on each clock edge, registered outputs still hold pre-edge values
   always @(posedge clk_in)
   begin
      if (!reset_in && !pc_reload)
      begin
         if (hold_chk)
         begin
            n_stall++;
            assert (f2d_valid && (f2d_data == held)) else report_value("f2d_data", held, f2d_data);
         end
         hold_chk = f2d_valid && !f2d_ready;
         held     = f2d_data;
         if (f2d_valid && f2d_ready)
            check_entry(f2d_data);
      end
      else
         hold_chk = 1'b0;                          // a flush may change the head
   end

   // cache side: idle out of reset, request and address held until the transfer
   always @(posedge clk_in)
   begin
      if (reset_in)
      begin
         req_open   = 1'b0;
         from_reset = 1'b1;
      end
      else
      begin
         if (from_reset)
         begin
            assert (!ic_req) else report_value("ic_req", 96'd0, ic_req);
            assert (!f2d_valid) else report_value("f2d_valid", 96'd0, f2d_valid);
            from_reset = 1'b0;
         end
         if (req_open)
         begin
            assert (ic_req) else report_value("ic_req", 96'd1, ic_req);
            assert (ic_addr == req_addr) else report_value("ic_addr", req_addr, ic_addr);
         end
         req_open = ic_req && !ic_resp.ack;        // a reload does not end the request
         req_addr = ic_addr;
      end
   end

   always @(posedge clk_in)
   begin
      cycles++;
      if (cycles == MAX_CYCLES)
      begin
         $display("timeout: the program did not finish within %0d cycles", MAX_CYCLES);
         end_run(1'b1);
      end
   end

   // --------------------
   // stimulus
   // --------------------
   task automatic pulse_reload(input logic [31:0] addr);
      pc_reload      = 1'b1;
      pc_reload_addr = addr;
      f2d_ready      = 1'b0;
      exp_pc         = addr;                       // nothing from the old path may follow
      n_reload++;
      @(negedge clk_in);
      pc_reload      = 1'b0;
   endtask

   task automatic reload_when_requesting(input logic [31:0] addr);
      while (!ic_req)
      begin
         f2d_ready = ($urandom % 10) >= 3;         // decode drains until a request is out
         @(negedge clk_in);
      end
      pulse_reload(addr);
   endtask

   task automatic reload_when_full(input logic [31:0] addr);
      f2d_ready = 1'b0;
      while (!DUT.u_que.full)
         @(negedge clk_in);
      pulse_reload(addr);
   endtask

   initial
   begin
      void'($urandom(32'h8b26632e));
      reset_in       = 1'b1;
      pc_reload      = 1'b0;
      pc_reload_addr = '0;
      f2d_ready      = 1'b0;
      exp_pc         = fetch_pkg::RESET_VECTOR;
      hold_chk       = 1'b0;
      {loop_exit, pass_end, run_done} = '0;
      {errors, n_accept, n_return, n_reload, n_stall} = '0;
      {loop_hits, passes, cycles} = '0;
      repeat (2) @(negedge clk_in);
      reset_in = 1'b0;
      while (!run_done)
      begin
         @(negedge clk_in);
         if (loop_exit)
         begin
            loop_exit = 1'b0;
            reload_when_requesting(exit_addr);
         end
         else if (pass_end)
         begin
            pass_end = 1'b0;
            if (passes == 1)
               reload_when_full(PASS2_BASE);
            else
               run_done = 1'b1;
         end
         else
            f2d_ready = ($urandom % 10) >= 3;      // about 30 percent stalls
      end
      assert (n_return >= 4)
         else report_failure("fewer returns were checked than the program holds");
      assert (n_stall > 0) else report_failure("no stall with a valid entry was seen");
      end_run(1'b0);
   end

endmodule

/* project.f */
design/fetch_pkg.sv
design/line_requester.sv
design/line_predecoder.sv
design/return_stack.sv
design/instr_queue.sv
design/fetch_unit.sv
dv/icache_model.sv
dv/fetch_unit_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the fetch stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module fetch_unit_tb -f project.f
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

./obj_dir/Vfetch_unit_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "ERRORS FOUND" "$LOG"; then
   exit 1
fi
exit 0
